//--- design/mcu_pkg.sv
/*
 * Shared widths, flag positions and enums for the 16-bit core.
 * Opcodes outside opcode_t execute as NOP. Flags sit in a 4-bit word.
 */

package mcu_pkg;

    localparam int data_w    = 16;
    localparam int addr_w    = 24;
    localparam int reg_cnt   = 8;
    localparam int reg_sel_w = 3;
    localparam int flag_w    = 4;

    // bit positions inside the flag word
    localparam int flag_z = 0;
    localparam int flag_c = 1;
    localparam int flag_s = 2;
    localparam int flag_v = 3;

    // dump addresses 0-15 are register bytes, low byte first
    localparam logic [7:0] dmp_flags_addr = 8'd16;

    typedef enum logic [4:0] {
        op_nop  = 5'd0,
        op_ldi  = 5'd1,
        op_ld   = 5'd2,
        op_add  = 5'd3,
        op_sub  = 5'd4,
        op_and  = 5'd5,
        op_or   = 5'd6,
        op_xor  = 5'd7,
        op_ldm  = 5'd8,
        op_stm  = 5'd9,
        op_jr   = 5'd10,
        op_jrz  = 5'd11,
        op_djnz = 5'd12,
        op_halt = 5'd13
    } opcode_t;

    // alu_mov copies op1, used by LD
    typedef enum logic [2:0] {
        alu_pass = 3'd0,
        alu_add  = 3'd1,
        alu_sub  = 3'd2,
        alu_and  = 3'd3,
        alu_or   = 3'd4,
        alu_xor  = 3'd5,
        alu_dec  = 3'd6,
        alu_mov  = 3'd7
    } alu_op_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_wait_op,
        st_exec,
        st_wait_mem,
        st_halt
    } ctrl_state_t;

endpackage

//--- design/mcu_regs.sv
/*
 * Eight 16-bit registers, two combinational read ports, one write port.
 * Dump port is combinational: 0-15 register bytes, 16 flags, else zero.
 */

`timescale 1ns/10ps

module mcu_regs(
    input                                 rst,
    input                                 clk,
    input                                 cen,

    input        [mcu_pkg::reg_sel_w-1:0] rd_sel,
    input        [mcu_pkg::reg_sel_w-1:0] rs_sel,
    input                                 reg_we,
    input                                 reg_wsrc,
    input        [mcu_pkg::data_w-1:0]    alu_dout,
    input        [mcu_pkg::data_w-1:0]    mem_dout,

    output       [mcu_pkg::data_w-1:0]    rd_out,
    output       [mcu_pkg::data_w-1:0]    rs_out,

    // register dump
    input        [7:0]                    dmp_addr,
    input        [mcu_pkg::flag_w-1:0]    flags,
    output logic [7:0]                    dmp_din
);

import mcu_pkg::*;

logic [data_w-1:0] regs[reg_cnt];
logic [data_w-1:0] dmp_word;

assign rd_out = regs[rd_sel];
assign rs_out = regs[rs_sel];

// reg_wsrc high takes the word from the RAM controller
always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < reg_cnt; i++) begin
            regs[i] <= '0;
        end
    end else if (cen && reg_we) begin
        regs[rd_sel] <= reg_wsrc ? mem_dout : alu_dout;
    end
end

// two dump bytes per register
assign dmp_word = regs[dmp_addr[3:1]];

always_comb begin
    dmp_din = 8'h00;
    if (dmp_addr < dmp_flags_addr) begin
        dmp_din = dmp_addr[0] ? dmp_word[15:8] : dmp_word[7:0];
    end else if (dmp_addr == dmp_flags_addr) begin
        dmp_din = {{(8 - flag_w){1'b0}}, flags};
    end
end

endmodule

//--- design/mcu_alu.sv
/*
 * Combinational 16-bit ALU plus the Z/C/S/V flag register.
 * C after subtract is the borrow. Logic ops clear C and V.
 * Flags change only on flag_we, so DJNZ leaves them alone.
 */

`timescale 1ns/10ps

module mcu_alu(
    input                                   rst,
    input                                   clk,
    input                                   cen,

    input        [mcu_pkg::data_w-1:0]      op0,
    input        [mcu_pkg::data_w-1:0]      op1,
    input        [7:0]                      imm8,
    input  mcu_pkg::alu_op_t                alu_op,
    input                                   flag_we,

    output logic [mcu_pkg::data_w-1:0]      alu_dout,
    output                                  alu_zero,
    output logic [mcu_pkg::flag_w-1:0]      flags
);

import mcu_pkg::*;

logic [data_w:0]   sum;
logic [data_w:0]   diff;
logic              carry;
logic              ovf;
logic [flag_w-1:0] flags_nx;

// extra top bit holds carry out / borrow
assign sum  = {1'b0, op0} + {1'b0, op1};
assign diff = {1'b0, op0} - {1'b0, op1};

always_comb begin
    alu_dout = op0;
    carry    = 1'b0;
    ovf      = 1'b0;
    case (alu_op)
        alu_pass: alu_dout = {{(data_w - 8){1'b0}}, imm8};
        alu_mov:  alu_dout = op1;
        alu_add: begin
            alu_dout = sum[data_w-1:0];
            carry    = sum[data_w];
            ovf      = (op0[data_w-1] == op1[data_w-1]) && (sum[data_w-1] != op0[data_w-1]);
        end
        alu_sub: begin
            alu_dout = diff[data_w-1:0];
            carry    = diff[data_w];
            ovf      = (op0[data_w-1] != op1[data_w-1]) && (diff[data_w-1] != op0[data_w-1]);
        end
        alu_and:  alu_dout = op0 & op1;
        alu_or:   alu_dout = op0 | op1;
        alu_xor:  alu_dout = op0 ^ op1;
        alu_dec:  alu_dout = op0 - data_w'(1);
        default:  alu_dout = op0;
    endcase
end

assign alu_zero = alu_dout == '0;

always_comb begin
    flags_nx         = '0;
    flags_nx[flag_z] = alu_zero;
    flags_nx[flag_c] = carry;
    flags_nx[flag_s] = alu_dout[data_w-1];
    flags_nx[flag_v] = ovf;
end

always_ff @(posedge clk) begin
    if (rst) begin
        flags <= '0;
    end else if (cen && flag_we) begin
        flags <= flags_nx;
    end
end

endmodule

//--- design/mcu_pc.sv
/*
 * Byte address of the next fetch, always even.
 * pc_inc and pc_rel are never pulsed together.
 */

`timescale 1ns/10ps

module mcu_pc(
    input                                 rst,
    input                                 clk,
    input                                 cen,

    input                                 pc_inc,
    input                                 pc_rel,
    input        [7:0]                    imm8,

    output logic [mcu_pkg::addr_w-1:0]    pc
);

import mcu_pkg::*;

logic [addr_w-1:0] rel_offset;

// signed word offset scaled to bytes
assign rel_offset = {{(addr_w - 9){imm8[7]}}, imm8, 1'b0};

always_ff @(posedge clk) begin
    if (rst) begin
        pc <= '0;
    end else if (cen) begin
        if (pc_inc) begin
            pc <= pc + addr_w'(2);
        end else if (pc_rel) begin
            pc <= pc + rel_offset;
        end
    end
end

endmodule

//--- design/mcu_ramctl.sv
/*
 * RAM access with fixed latency: request in cycle n, mem_rdy in cycle n+2.
 * External RAM must return read data one enabled cycle after the address.
 * Writes are always full words on an even address.
 */

`timescale 1ns/10ps

module mcu_ramctl(
    input                                 rst,
    input                                 clk,
    input                                 cen,

    input        [mcu_pkg::addr_w-1:0]    pc,
    input        [mcu_pkg::addr_w-1:0]    mem_addr,
    input                                 mem_sel_pc,
    input                                 mem_req,
    input                                 mem_write,
    input        [mcu_pkg::data_w-1:0]    wr_data,

    // RAM interface
    output       [mcu_pkg::addr_w-1:0]    ram_addr,
    input        [mcu_pkg::data_w-1:0]    ram_dout,
    output       [mcu_pkg::data_w-1:0]    ram_din,
    output       [1:0]                    ram_we,

    output logic [mcu_pkg::data_w-1:0]    mem_dout,
    output logic                          mem_rdy
);

import mcu_pkg::*;

logic [addr_w-1:0] req_addr;
logic [addr_w-1:0] addr_hold;
logic              pend;

assign req_addr = mem_sel_pc ? pc : mem_addr;

// address goes out in the request cycle, then stays put
assign ram_addr = mem_req ? req_addr : addr_hold;
assign ram_we   = (mem_req && mem_write) ? 2'b11 : 2'b00;
assign ram_din  = wr_data;

always_ff @(posedge clk) begin
    if (rst) begin
        pend    <= 1'b0;
        mem_rdy <= 1'b0;
    end else if (cen) begin
        pend    <= mem_req;
        mem_rdy <= pend;
    end
end

// RAM data is valid one cycle after the request
always_ff @(posedge clk) begin
    if (cen) begin
        if (mem_req) begin
            addr_hold <= req_addr;
        end
        if (pend) begin
            mem_dout <= ram_dout;
        end
    end
end

endmodule

//--- design/mcu_ctrl.sv
/*
 * Fetch/execute FSM. Every instruction is one word.
 * Only one RAM request is outstanding at a time.
 * HALT is left only through reset.
 */

`timescale 1ns/10ps

module mcu_ctrl(
    input                                 rst,
    input                                 clk,
    input                                 cen,

    // memory
    input        [mcu_pkg::data_w-1:0]    mem_dout,
    input                                 mem_rdy,
    output logic                          mem_req,
    output logic                          mem_sel_pc,
    output logic                          mem_write,

    // program counter
    output logic                          pc_inc,
    output logic                          pc_rel,
    output       [7:0]                    imm8,

    // registers and ALU
    output       [mcu_pkg::reg_sel_w-1:0] rd_sel,
    output       [mcu_pkg::reg_sel_w-1:0] rs_sel,
    output logic                          reg_we,
    output logic                          reg_wsrc,
    output mcu_pkg::alu_op_t              alu_op,
    output logic                          flag_we,
    input                                 alu_zero,
    input        [mcu_pkg::flag_w-1:0]    flags,

    output                                halted
);

import mcu_pkg::*;

ctrl_state_t       state;
ctrl_state_t       st_nx;
logic [data_w-1:0] ir;
opcode_t           op;

// instruction fields
assign op     = opcode_t'(ir[15:11]);
assign rd_sel = ir[10:8];
assign rs_sel = ir[2:0];
assign imm8   = ir[7:0];
assign halted = state == st_halt;

always_comb begin
    st_nx      = state;
    mem_req    = 1'b0;
    mem_sel_pc = 1'b0;
    mem_write  = 1'b0;
    pc_inc     = 1'b0;
    pc_rel     = 1'b0;
    reg_we     = 1'b0;
    reg_wsrc   = 1'b0;
    alu_op     = alu_pass;
    flag_we    = 1'b0;
    case (state)
        st_fetch: begin
            mem_req    = 1'b1;
            mem_sel_pc = 1'b1;
            st_nx      = st_wait_op;
        end
        st_wait_op: begin
            if (mem_rdy) begin
                pc_inc = 1'b1;
                st_nx  = st_exec;
            end
        end
        st_exec: begin
            st_nx = st_fetch;
            case (op)
                op_ldi: begin
                    reg_we = 1'b1;
                    alu_op = alu_pass;
                end
                op_ld: begin
                    reg_we = 1'b1;
                    alu_op = alu_mov;
                end
                op_add, op_sub, op_and, op_or, op_xor: begin
                    reg_we  = 1'b1;
                    flag_we = 1'b1;
                    case (op)
                        op_add:  alu_op = alu_add;
                        op_sub:  alu_op = alu_sub;
                        op_and:  alu_op = alu_and;
                        op_or:   alu_op = alu_or;
                        default: alu_op = alu_xor;
                    endcase
                end
                op_ldm, op_stm: begin
                    mem_req   = 1'b1;
                    mem_write = op == op_stm;
                    st_nx     = st_wait_mem;
                end
                op_jr:   pc_rel = 1'b1;
                op_jrz:  pc_rel = flags[flag_z];
                op_djnz: begin
                    // alu_zero reflects the decremented value
                    reg_we = 1'b1;
                    alu_op = alu_dec;
                    pc_rel = !alu_zero;
                end
                op_halt: st_nx = st_halt;
                default: st_nx = st_fetch;
            endcase
        end
        st_wait_mem: begin
            if (mem_rdy) begin
                reg_we   = op == op_ldm;
                reg_wsrc = 1'b1;
                st_nx    = st_fetch;
            end
        end
        default: st_nx = state;
    endcase
end

always_ff @(posedge clk) begin
    if (rst) begin
        state <= st_fetch;
        ir    <= '0;
    end else if (cen) begin
        state <= st_nx;
        if (state == st_wait_op && mem_rdy) begin
            ir <= mem_dout;
        end
    end
end

endmodule

//--- design/mcu_core.sv
/*
 * 16-bit CPU top level. RAM returns read data one enabled cycle after
 * the address. cen low freezes the whole core. halted rises on HALT.
 */

`timescale 1ns/10ps

module mcu_core(
    input                              rst,
    input                              clk,
    input                              cen,

    output [mcu_pkg::addr_w-1:0]       ram_addr,
    input  [mcu_pkg::data_w-1:0]       ram_dout,
    output [mcu_pkg::data_w-1:0]       ram_din,
    output [1:0]                       ram_we,
    // register dump
    input  [7:0]                       dmp_addr,
    output [7:0]                       dmp_din,

    output                             halted
);

import mcu_pkg::*;

// register bank
logic [reg_sel_w-1:0] rd_sel, rs_sel;
logic [data_w-1:0]    rd_out, rs_out;
logic                 reg_we, reg_wsrc;

// PC control
logic [addr_w-1:0]    pc;
logic                 pc_inc, pc_rel;
logic [7:0]           imm8;

// ALU control
alu_op_t              alu_op;
logic [data_w-1:0]    alu_dout;
logic [flag_w-1:0]    flags;
logic                 flag_we, alu_zero;

// memory controller
logic                 mem_req, mem_sel_pc, mem_write, mem_rdy;
logic [data_w-1:0]    mem_dout;

mcu_ctrl u_ctrl(
    .rst        ( rst           ),
    .clk        ( clk           ),
    .cen        ( cen           ),
    .mem_dout   ( mem_dout      ),
    .mem_rdy    ( mem_rdy       ),
    .mem_req    ( mem_req       ),
    .mem_sel_pc ( mem_sel_pc    ),
    .mem_write  ( mem_write     ),
    .pc_inc     ( pc_inc        ),
    .pc_rel     ( pc_rel        ),
    .imm8       ( imm8          ),
    .rd_sel     ( rd_sel        ),
    .rs_sel     ( rs_sel        ),
    .reg_we     ( reg_we        ),
    .reg_wsrc   ( reg_wsrc      ),
    .alu_op     ( alu_op        ),
    .flag_we    ( flag_we       ),
    .alu_zero   ( alu_zero      ),
    .flags      ( flags         ),
    .halted     ( halted        )
);

mcu_regs u_regs(
    .rst        ( rst           ),
    .clk        ( clk           ),
    .cen        ( cen           ),
    .rd_sel     ( rd_sel        ),
    .rs_sel     ( rs_sel        ),
    .reg_we     ( reg_we        ),
    .reg_wsrc   ( reg_wsrc      ),
    .alu_dout   ( alu_dout      ),
    .mem_dout   ( mem_dout      ),
    .rd_out     ( rd_out        ),
    .rs_out     ( rs_out        ),
    .dmp_addr   ( dmp_addr      ),
    .flags      ( flags         ),
    .dmp_din    ( dmp_din       )
);

mcu_alu u_alu(
    .rst        ( rst           ),
    .clk        ( clk           ),
    .cen        ( cen           ),
    .op0        ( rd_out        ),
    .op1        ( rs_out        ),
    .imm8       ( imm8          ),
    .alu_op     ( alu_op        ),
    .flag_we    ( flag_we       ),
    .alu_dout   ( alu_dout      ),
    .alu_zero   ( alu_zero      ),
    .flags      ( flags         )
);

mcu_pc u_pc(
    .rst        ( rst           ),
    .clk        ( clk           ),
    .cen        ( cen           ),
    .pc_inc     ( pc_inc        ),
    .pc_rel     ( pc_rel        ),
    .imm8       ( imm8          ),
    .pc         ( pc            )
);

// data accesses use rs as a byte address, forced even
mcu_ramctl u_ramctl(
    .rst        ( rst           ),
    .clk        ( clk           ),
    .cen        ( cen           ),
    .pc         ( pc            ),
    .mem_addr   ( {{(addr_w - data_w){1'b0}}, rs_out[data_w-1:1], 1'b0} ),
    .mem_sel_pc ( mem_sel_pc    ),
    .mem_req    ( mem_req       ),
    .mem_write  ( mem_write     ),
    .wr_data    ( rd_out        ),
    .ram_addr   ( ram_addr      ),
    .ram_dout   ( ram_dout      ),
    .ram_din    ( ram_din       ),
    .ram_we     ( ram_we        ),
    .mem_dout   ( mem_dout      ),
    .mem_rdy    ( mem_rdy       )
);

endmodule

//--- tb/tb_mcu_core.sv
/*
 * Directed testbench for mcu_core. The RAM model holds 256 words at byte
 * address bits 8:1 with a registered read, and is loaded one word per clock.
 * Results are read through the dump port once halted rises.
 */

`timescale 1ns/10ps

module tb_mcu_core;

import mcu_pkg::*;

logic                clk;
logic                rst;
logic                cen;
logic [addr_w-1:0]   ram_addr;
logic [data_w-1:0]   ram_dout = '0;
logic [data_w-1:0]   ram_din;
logic [1:0]          ram_we;
logic [7:0]          dmp_addr;
logic [7:0]          dmp_din;
logic                halted;

// RAM model with its load port
logic [data_w-1:0]   ram_words[256];
logic                load_en;
logic [7:0]          load_idx;
logic [data_w-1:0]   load_data;
int                  full_writes = 0;
int                  partial_writes = 0;

logic [15:0]         prog[$];
bit                  rand_cen;
integer              seed;
string               mode;
string               cur_test;
string               step;
int                  errors;
int                  checks;
int                  tests;
int                  failed_tests;

mcu_core i_dut(
    .rst      ( rst      ),
    .clk      ( clk      ),
    .cen      ( cen      ),
    .ram_addr ( ram_addr ),
    .ram_dout ( ram_dout ),
    .ram_din  ( ram_din  ),
    .ram_we   ( ram_we   ),
    .dmp_addr ( dmp_addr ),
    .dmp_din  ( dmp_din  ),
    .halted   ( halted   )
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

always @(posedge clk) begin
    if (load_en) begin
        ram_words[load_idx] <= load_data;
    end else if (cen) begin
        if (ram_we[0]) begin
            ram_words[ram_addr[8:1]][7:0] <= ram_din[7:0];
        end
        if (ram_we[1]) begin
            ram_words[ram_addr[8:1]][15:8] <= ram_din[15:8];
        end
        if (ram_we == 2'b11) begin
            full_writes <= full_writes + 1;
        end else if (ram_we != 2'b00) begin
            partial_writes <= partial_writes + 1;
        end
        ram_dout <= ram_words[ram_addr[8:1]];
    end
end

// instruction words, layout op[15:11] rd[10:8] imm8 or rs[2:0]
function automatic logic [15:0] imm_word(opcode_t op, logic [2:0] rd, logic [7:0] imm);
    return {op, rd, imm};
endfunction

function automatic logic [15:0] reg_word(opcode_t op, logic [2:0] rd, logic [2:0] rs);
    return {op, rd, 5'b00000, rs};
endfunction

function automatic logic [flag_w-1:0] flag_word(bit z, bit c, bit s, bit v);
    logic [flag_w-1:0] f;
    f         = '0;
    f[flag_z] = z;
    f[flag_c] = c;
    f[flag_s] = s;
    f[flag_v] = v;
    return f;
endfunction

// high byte shifted up by eight self-adds, low byte ORed in through r7
task automatic const_to_reg(input logic [2:0] rd, input logic [15:0] value);
    prog.push_back(imm_word(op_ldi, rd, value[15:8]));
    repeat (8) prog.push_back(reg_word(op_add, rd, rd));
    prog.push_back(imm_word(op_ldi, 3'd7, value[7:0]));
    prog.push_back(reg_word(op_or, rd, 3'd7));
endtask

task automatic next_cycle();
    @(negedge clk);
    if (rand_cen) begin
        cen = ($random(seed) % 4) != 0;
    end else begin
        cen = 1'b1;
    end
endtask

task automatic load_program();
    for (int i = 0; i < 256; i++) begin
        next_cycle();
        load_en   = 1'b1;
        load_idx  = 8'(i);
        load_data = (i < prog.size()) ? prog[i] : (16'hee00 | 16'(i));
    end
    next_cycle();
    load_en = 1'b0;
endtask

task automatic reset_core();
    next_cycle();
    rst = 1'b1;
    repeat (2) next_cycle();
    rst = 1'b0;
endtask

task automatic wait_halt(output bit ok);
    int cycles;
    cycles = 0;
    while (!halted && cycles < 2000) begin
        next_cycle();
        cycles++;
    end
    ok = halted;
    if (!ok) begin
        errors++;
        $display("%s%s, %s: timeout, halted did not rise within 2000 cycles",
                 cur_test, mode, step);
    end
endtask

task automatic run_program(output bit ok);
    reset_core();
    wait_halt(ok);
endtask

task automatic dump_byte(input logic [7:0] addr, output logic [7:0] value);
    next_cycle();
    dmp_addr = addr;
    next_cycle();
    value = dmp_din;
endtask

task automatic check_word(input string what, input logic [data_w-1:0] got,
                          input logic [data_w-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAIL %0t: %s%s, %s: %s is %h, expected %h",
                 $time, cur_test, mode, step, what, got, exp);
    end
endtask

task automatic check_flags(input logic [flag_w-1:0] got, input logic [flag_w-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAIL %0t: %s%s, %s: flags VSCZ are %b, expected %b",
                 $time, cur_test, mode, step, got, exp);
    end
endtask

task automatic check_mem(input logic [addr_w-1:0] addr, input logic [data_w-1:0] exp);
    logic [data_w-1:0] got;
    got = ram_words[addr[8:1]];
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAIL %0t: %s%s, %s: RAM at %h is %h, expected %h",
                 $time, cur_test, mode, step, addr, got, exp);
    end
endtask

task automatic verify_reg(input logic [reg_sel_w-1:0] n, input logic [data_w-1:0] exp);
    logic [7:0] lo;
    logic [7:0] hi;
    dump_byte({4'b0000, n, 1'b0}, lo);
    dump_byte({4'b0000, n, 1'b1}, hi);
    check_word($sformatf("r%0d", n), {hi, lo}, exp);
endtask

task automatic verify_flags(input logic [flag_w-1:0] exp);
    logic [7:0] b;
    dump_byte(dmp_flags_addr, b);
    check_flags(b[flag_w-1:0], exp);
endtask

task automatic report_test(input int err0);
    tests++;
    if (errors == err0) begin
        $display("%s%s: ok", cur_test, mode);
    end else begin
        failed_tests++;
        $display("%s%s: %0d errors", cur_test, mode, errors - err0);
    end
endtask

task automatic alu_case(input opcode_t op, input logic [data_w-1:0] a,
                        input logic [data_w-1:0] b, input logic [data_w-1:0] exp,
                        input logic [flag_w-1:0] exp_flags);
    bit ok;
    step = $sformatf("%s %h,%h", op.name(), a, b);
    prog.delete();
    const_to_reg(3'd1, a);
    const_to_reg(3'd2, b);
    // 0x8000 + 0x8000 leaves Z, C and V set ahead of the tested op
    const_to_reg(3'd3, 16'h8000);
    prog.push_back(reg_word(op_add, 3'd3, 3'd3));
    prog.push_back(reg_word(op, 3'd1, 3'd2));
    // LDI and LD keep the flags of the tested op
    prog.push_back(imm_word(op_ldi, 3'd6, 8'h00));
    prog.push_back(reg_word(op_ld, 3'd5, 3'd1));
    prog.push_back(imm_word(op_halt, 3'd0, 8'h00));
    load_program();
    run_program(ok);
    if (ok) begin
        verify_reg(3'd1, exp);
        verify_reg(3'd5, exp);
        verify_reg(3'd6, 16'h0000);
        verify_flags(exp_flags);
    end
endtask

task automatic alu_test();
    int err0;
    err0     = errors;
    cur_test = "alu test";
    alu_case(op_add, 16'h7fff, 16'h0001, 16'h8000, flag_word(1'b0, 1'b0, 1'b1, 1'b1));
    alu_case(op_add, 16'hffff, 16'h0001, 16'h0000, flag_word(1'b1, 1'b1, 1'b0, 1'b0));
    alu_case(op_sub, 16'h0005, 16'h0007, 16'hfffe, flag_word(1'b0, 1'b1, 1'b1, 1'b0));
    alu_case(op_sub, 16'h8000, 16'h0001, 16'h7fff, flag_word(1'b0, 1'b0, 1'b0, 1'b1));
    alu_case(op_sub, 16'h1234, 16'h1234, 16'h0000, flag_word(1'b1, 1'b0, 1'b0, 1'b0));
    alu_case(op_and, 16'hf0f0, 16'h0ff0, 16'h00f0, flag_word(1'b0, 1'b0, 1'b0, 1'b0));
    alu_case(op_or,  16'h8000, 16'h0001, 16'h8001, flag_word(1'b0, 1'b0, 1'b1, 1'b0));
    alu_case(op_xor, 16'ha5a5, 16'ha5a5, 16'h0000, flag_word(1'b1, 1'b0, 1'b0, 1'b0));
    report_test(err0);
endtask

task automatic mem_program();
    prog.delete();
    // r2 goes last so S is still set when the stores begin
    const_to_reg(3'd4, 16'h1234);
    const_to_reg(3'd2, 16'hbeef);
    prog.push_back(imm_word(op_ldi, 3'd1, 8'h80));
    // odd address, bit 0 is dropped
    prog.push_back(imm_word(op_ldi, 3'd3, 8'h83));
    prog.push_back(reg_word(op_stm, 3'd2, 3'd1));
    prog.push_back(reg_word(op_stm, 3'd4, 3'd3));
    prog.push_back(reg_word(op_ldm, 3'd5, 3'd1));
    prog.push_back(reg_word(op_ldm, 3'd6, 3'd3));
    prog.push_back(imm_word(op_ldi, 3'd0, 8'h82));
    prog.push_back(reg_word(op_ldm, 3'd7, 3'd0));
    prog.push_back(imm_word(op_halt, 3'd0, 8'h00));
endtask

task automatic mem_results();
    check_mem(24'h000080, 16'hbeef);
    check_mem(24'h000082, 16'h1234);
    verify_reg(3'd5, 16'hbeef);
    verify_reg(3'd6, 16'h1234);
    verify_reg(3'd7, 16'h1234);
endtask

task automatic mem_test();
    int err0;
    int full0;
    int part0;
    bit ok;
    err0     = errors;
    full0    = full_writes;
    part0    = partial_writes;
    cur_test = "memory test";
    step     = "STM/LDM";
    mem_program();
    load_program();
    run_program(ok);
    if (ok) begin
        mem_results();
        checks++;
        if (full_writes - full0 != 2 || partial_writes != part0) begin
            errors++;
            $display("FAIL %0t: %s%s: %0d full-word and %0d partial writes, expected 2 and 0",
                     $time, cur_test, mode, full_writes - full0, partial_writes - part0);
        end
    end
    report_test(err0);
endtask

task automatic branch_program();
    prog.delete();
    prog.push_back(imm_word(op_ldi, 3'd1, 8'h01));
    prog.push_back(imm_word(op_jr, 3'd0, 8'h01));
    prog.push_back(imm_word(op_ldi, 3'd1, 8'h99));
    prog.push_back(imm_word(op_ldi, 3'd2, 8'h05));
    prog.push_back(imm_word(op_ldi, 3'd3, 8'h05));
    prog.push_back(reg_word(op_sub, 3'd3, 3'd2));
    prog.push_back(imm_word(op_jrz, 3'd0, 8'h01));
    prog.push_back(imm_word(op_ldi, 3'd2, 8'h77));
    prog.push_back(imm_word(op_ldi, 3'd4, 8'h03));
    prog.push_back(reg_word(op_sub, 3'd4, 3'd2));
    prog.push_back(imm_word(op_jrz, 3'd0, 8'h01));
    prog.push_back(imm_word(op_ldi, 3'd5, 8'h11));
    // sum of 10 down to 1 into r0
    prog.push_back(imm_word(op_ldi, 3'd6, 8'h0a));
    prog.push_back(imm_word(op_ldi, 3'd0, 8'h00));
    prog.push_back(reg_word(op_add, 3'd0, 3'd6));
    prog.push_back(imm_word(op_djnz, 3'd6, 8'hfe));
    prog.push_back(imm_word(op_halt, 3'd0, 8'h00));
endtask

task automatic branch_results();
    verify_reg(3'd0, 16'd55);
    verify_reg(3'd1, 16'h0001);
    verify_reg(3'd2, 16'h0005);
    verify_reg(3'd3, 16'h0000);
    verify_reg(3'd4, 16'hfffe);
    verify_reg(3'd5, 16'h0011);
    verify_reg(3'd6, 16'h0000);
    verify_flags(flag_word(1'b0, 1'b0, 1'b0, 1'b0));
endtask

task automatic branch_test();
    int err0;
    bit ok;
    err0     = errors;
    cur_test = "branch test";
    step     = "JR/JRZ/DJNZ";
    branch_program();
    load_program();
    run_program(ok);
    if (ok) begin
        branch_results();
    end
    report_test(err0);
endtask

task automatic reset_test();
    int err0;
    int cycles;
    bit ok;
    err0     = errors;
    cur_test = "reset test";
    step     = "reset mid-program";
    mem_program();
    load_program();
    reset_core();
    // run until the first store drives the RAM
    cycles = 0;
    while (ram_we !== 2'b11 && !halted && cycles < 2000) begin
        next_cycle();
        cycles++;
    end
    if (ram_we !== 2'b11) begin
        errors++;
        $display("%s%s: no RAM store was seen before the reset was applied",
                 cur_test, mode);
    end
    rst = 1'b1;
    repeat (2) next_cycle();
    checks++;
    if (ram_we !== 2'b00 || halted !== 1'b0) begin
        errors++;
        $display("FAIL %0t: %s%s: ram_we is %b and halted is %b during reset",
                 $time, cur_test, mode, ram_we, halted);
    end
    for (int n = 0; n < reg_cnt; n++) begin
        verify_reg(3'(n), '0);
    end
    verify_flags('0);
    rst  = 1'b0;
    step = "rerun after reset";
    wait_halt(ok);
    if (ok) begin
        mem_results();
    end
    report_test(err0);
endtask

initial begin
    rst          = 1'b1;
    cen          = 1'b1;
    dmp_addr     = 8'h00;
    load_en      = 1'b0;
    load_idx     = 8'h00;
    load_data    = '0;
    rand_cen     = 1'b0;
    seed         = 44656;
    mode         = "";
    errors       = 0;
    checks       = 0;
    tests        = 0;
    failed_tests = 0;
    alu_test();
    mem_test();
    branch_test();
    reset_test();
    rand_cen = 1'b1;
    mode     = " with random cen";
    alu_test();
    mem_test();
    branch_test();
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
        $display("Test passed");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule

//--- sim.f
design/mcu_pkg.sv
design/mcu_regs.sv
design/mcu_alu.sv
design/mcu_pc.sv
design/mcu_ramctl.sv
design/mcu_ctrl.sv
design/mcu_core.sv
tb/tb_mcu_core.sv

//--- Makefile
# Verilator build and run for the mcu_core testbench

TOP       ?= tb_mcu_core
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LOG       ?= sim.log

SRCS := $(shell cat sim.f)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): sim.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f sim.f

# the log decides pass or fail
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
